//--- flist.f
verilog/delay_tune_pkg.sv
verilog/adjust_if.sv
verilog/button_sync.sv
verilog/key_debounce.sv
verilog/delay_select_ctrl.sv
verilog/delay_value_bank.sv
verilog/delay_tune_top.sv
testbench/delay_tune_assert.sv
testbench/tb_delay_tune.sv

//--- Makefile
# Verilator build and run for the delay tune panel
# Any variable can be overridden, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_delay_tune
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Everything OK

SRCS    = $(shell cat $(FLIST))
SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only if the simulation prints the pass message on a line of its own
run: compile
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_delay_tune.sv
// --------------------
// Delay tune panel testbench
// Presses buttons through the debouncers and
// checks the settings against a reference model
// --------------------
`timescale 1ns/1ps

module tb_delay_tune;
  import delay_tune_pkg::*;

  localparam int unsigned DEB_CYC  = 16;
  localparam int unsigned IDLE_CYC = 64;
  localparam int HOLD_CYC  = 30;
  localparam int SHORT_CYC = DEB_CYC / 2;        // Too short to be accepted
  localparam int IDLE_WAIT = IDLE_CYC + 36;
  localparam int PRESS_CYC = 2 * HOLD_CYC + 2;   // One press and its check
  // Reset, 19 presses, two idle waits, the short pulse and some margin
  localparam int TOTAL_CYC = 8 + 19 * PRESS_CYC + 2 * IDLE_WAIT + SHORT_CYC + HOLD_CYC + 16;

  logic              clk_x10;
  logic              g_rst;
  logic              inverse;
  logic [NUM_CH-1:0] buttons;
  delay_arr_t        delay_value;
  delay_val_t        led_output;

  // --------------------
  // Reference model state
  delay_arr_t model_val;
  delay_val_t model_led;
  logic       model_sel_valid;
  int         model_sel_ch;

  integer seed;
  int     errors;
  int     tests_run;
  int     tests_failed;
  int     test_start_err;
  int     ch_a;
  int     ch_b;
  int     ch_c;

  delay_tune_top #(
    .DEBOUNCE_CYCLES (DEB_CYC),
    .IDLE_CYCLES     (IDLE_CYC)
  ) dut0 (
    .clk_x10     (clk_x10),
    .g_rst       (g_rst),
    .inverse     (inverse),
    .buttons     (buttons),
    .delay_value (delay_value),
    .led_output  (led_output)
  );

  initial
  begin
    clk_x10 = 1'b0;
    forever #5 clk_x10 = ~clk_x10;
  end

  function automatic delay_val_t next_setting(input delay_val_t v, input logic up);
    int span;
    int n;
    span = int'(DELAY_MAX) + 1;
    if (up)
      n = (int'(v) + 1) % span;
    else
      n = (int'(v) + span - 1) % span;
    return delay_val_t'(n);
  endfunction

  function automatic logic [NUM_CH-1:0] channel_mask(input int ch);
    logic [NUM_CH-1:0] m;
    m     = '0;
    m[ch] = 1'b1;
    return m;
  endfunction

  function automatic int pick_channel();
    return int'($unsigned($random(seed)) % NUM_CH);
  endfunction

  function automatic int pick_other(input int avoid);
    return (avoid + 1 + pick_channel() % (NUM_CH - 1)) % NUM_CH;
  endfunction

  task automatic model_press(input int ch);
    model_led = model_val[ch];  // LED shows the value before the step
    if (model_sel_valid && model_sel_ch == ch)
      model_val[ch] = next_setting(model_val[ch], inverse);
    model_sel_valid = 1'b1;
    model_sel_ch    = ch;
  endtask

  task automatic press_buttons(input logic [NUM_CH-1:0] mask, input int hold_cyc);
    @(posedge clk_x10);
    buttons <= mask;
    repeat (hold_cyc) @(posedge clk_x10);
    buttons <= '0;
    repeat (HOLD_CYC) @(posedge clk_x10);
  endtask

  task automatic check_outputs();
    @(negedge clk_x10);
    assert (delay_value === model_val) else
    begin
      $display("MISMATCH delay_value: got 0x%h, expected 0x%h", delay_value, model_val);
      errors++;
    end
    assert (led_output === model_led) else
    begin
      $display("MISMATCH led_output: got 0x%h, expected 0x%h", led_output, model_led);
      errors++;
    end
  endtask

  task automatic press_channel(input int ch);
    press_buttons(channel_mask(ch), HOLD_CYC);
    model_press(ch);
    check_outputs();
  endtask

  task automatic set_inverse(input logic v);
    @(posedge clk_x10);
    inverse <= v;
  endtask

  task automatic idle_wait();
    repeat (IDLE_WAIT) @(posedge clk_x10);
    model_sel_valid = 1'b0;
  endtask

  task automatic finish_test(input int num, input string name);
    tests_run++;
    if (errors != test_start_err)
    begin
      tests_failed++;
      $display("test %0d %s: FAIL with %0d errors", num, name, errors - test_start_err);
    end
    else
      $display("test %0d %s: pass", num, name);
    test_start_err = errors;
  endtask

  // --------------------
  initial
  begin
    seed            = 32'hf823c87f;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    test_start_err  = 0;
    model_val       = '0;
    model_led       = '0;
    model_sel_valid = 1'b0;
    model_sel_ch    = 0;
    g_rst   <= 1'b1;
    inverse <= 1'b0;
    buttons <= '0;
    repeat (8) @(posedge clk_x10);
    g_rst <= 1'b0;

    check_outputs();
    finish_test(1, "reset values");

    ch_a = pick_channel();
    press_channel(ch_a);      // Show only
    set_inverse(1'b1);
    repeat (11) press_channel(ch_a);
    finish_test(2, "step up and wrap");

    set_inverse(1'b0);
    repeat (2) press_channel(ch_a);
    finish_test(3, "step down and wrap");

    ch_b = pick_other(ch_a);
    press_channel(ch_b);
    idle_wait();
    press_channel(ch_b);      // Selection cleared so only a show
    finish_test(4, "reselect and idle timeout");

    press_buttons(channel_mask(ch_a), SHORT_CYC);
    check_outputs();
    idle_wait();
    press_channel(ch_a);
    ch_c = (ch_b + 1) % NUM_CH;
    if (ch_c == ch_a)
      ch_c = (ch_c + 1) % NUM_CH;
    press_buttons(channel_mask(ch_b) | channel_mask(ch_c), HOLD_CYC);
    check_outputs();
    press_channel(ch_a);      // Still selected, so it steps
    finish_test(5, "short pulse and double press");

    $display("tests %0d, failed %0d, check errors %0d, assertion errors %0d",
             tests_run, tests_failed, errors, dut0.u_chk.fail_cnt);
    if (errors == 0 && tests_failed == 0 && dut0.u_chk.fail_cnt == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (2 * TOTAL_CYC) @(posedge clk_x10);
    $display("Watchdog expired after %0d cycles before the tests completed", 2 * TOTAL_CYC);
    $display("Something failed");
    $finish;
  end

endmodule

//--- testbench/delay_tune_assert.sv
// --------------------
// Delay panel checks
// Range, single change and step size of the
// settings, and output values in reset
// --------------------
`timescale 1ns/1ps

module delay_tune_assert (
  input logic                       clk_x10,
  input logic                       g_rst,
  input delay_tune_pkg::delay_arr_t delay_value,
  input delay_tune_pkg::delay_val_t led_output
);
  import delay_tune_pkg::*;

  int unsigned fail_range = 0;
  int unsigned fail_change = 0;
  int unsigned fail_step = 0;
  int unsigned fail_reset = 0;
  int unsigned fail_cnt;

  assign fail_cnt = fail_range + fail_change + fail_step + fail_reset;

  function automatic logic all_in_range(input delay_arr_t arr);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < NUM_CH; i++)
    begin
      if (arr[i] > DELAY_MAX)
        ok = 1'b0;
    end
    return ok;
  endfunction

  // Channels whose value moved since the last edge
  function automatic logic [NUM_CH-1:0] changed(input delay_arr_t cur, input delay_arr_t prev);
    logic [NUM_CH-1:0] m;
    for (int i = 0; i < NUM_CH; i++)
      m[i] = (cur[i] != prev[i]);
    return m;
  endfunction

  // Distance modulo DELAY_MAX+1 must be one count either way
  function automatic logic all_steps(input delay_arr_t cur, input delay_arr_t prev);
    int  span;
    int  d;
    logic ok;
    span = int'(DELAY_MAX) + 1;
    ok   = 1'b1;
    for (int i = 0; i < NUM_CH; i++)
    begin
      d = (int'(cur[i]) - int'(prev[i]) + span) % span;
      if (d != 0 && d != 1 && d != int'(DELAY_MAX))
        ok = 1'b0;
    end
    return ok;
  endfunction

  // --------------------
  value_range: assert property (@(posedge clk_x10) disable iff (g_rst)
    all_in_range(delay_value))
  else
  begin
    fail_range++;
    $error("a delay value is above the wrap limit");
  end

  one_change: assert property (@(posedge clk_x10) disable iff (g_rst)
    $onehot0(changed(delay_value, $past(delay_value))))
  else
  begin
    fail_change++;
    $error("more than one delay value changed in one cycle");
  end

  step_size: assert property (@(posedge clk_x10) disable iff (g_rst)
    all_steps(delay_value, $past(delay_value)))
  else
  begin
    fail_step++;
    $error("a delay value moved by more than one count");
  end

  reset_zero: assert property (@(posedge clk_x10)
    (g_rst && $past(g_rst)) |-> (delay_value == '0 && led_output == '0))
  else
  begin
    fail_reset++;
    $error("outputs are not zero during reset");
  end

endmodule

bind delay_tune_top delay_tune_assert u_chk (
  .clk_x10     (clk_x10),
  .g_rst       (g_rst),
  .delay_value (delay_value),
  .led_output  (led_output)
);

//--- verilog/delay_tune_top.sv
// --------------------
// Delay tune panel top
// Synchronizer, nine debouncers, selection
// controller and value bank
// --------------------
`timescale 1ns/1ps

module delay_tune_top #(
  parameter int unsigned DEBOUNCE_CYCLES = 1_000_000, // 5 ms at 200 MHz
  parameter int unsigned IDLE_CYCLES     = 400_000_000 // 2 s at 200 MHz
) (
  input  logic                              clk_x10,
  input  logic                              g_rst,
  input  logic                              inverse,
  input  logic [delay_tune_pkg::NUM_CH-1:0] buttons,
  output delay_tune_pkg::delay_arr_t        delay_value,
  output delay_tune_pkg::delay_val_t        led_output
);
  import delay_tune_pkg::*;

  logic [NUM_CH-1:0] buttons_sync;
  logic              inverse_sync;
  logic [NUM_CH-1:0] press;

  adjust_if adj_bus ();

  // --------------------
  // Input conditioning
  // --------------------
  button_sync u_sync (
    .clk_x10      (clk_x10),
    .g_rst        (g_rst),
    .buttons      (buttons),
    .inverse      (inverse),
    .buttons_sync (buttons_sync),
    .inverse_sync (inverse_sync)
  );

  // One debouncer per button
  for (genvar i = 0; i < NUM_CH; i++)
  begin : g_deb
    key_debounce #(
      .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_deb (
      .clk_x10   (clk_x10),
      .g_rst     (g_rst),
      .key       (buttons_sync[i]),
      .key_pulse (press[i])
    );
  end

  // --------------------
  // Control and storage
  // --------------------
  delay_select_ctrl #(
    .IDLE_CYCLES (IDLE_CYCLES)
  ) u_ctrl (
    .clk_x10      (clk_x10),
    .g_rst        (g_rst),
    .press        (press),
    .inverse_sync (inverse_sync),
    .adj          (adj_bus.ctrl)
  );

  delay_value_bank u_bank (
    .clk_x10     (clk_x10),
    .g_rst       (g_rst),
    .adj         (adj_bus.bank),
    .delay_value (delay_value),
    .led_output  (led_output)
  );

endmodule

//--- verilog/delay_value_bank.sv
// --------------------
// Delay value bank
// Holds the nine settings, applies wrapped
// steps and drives the LED value
// --------------------
`timescale 1ns/1ps

module delay_value_bank (
  input  logic                       clk_x10,
  input  logic                       g_rst,
  adjust_if.bank                     adj,
  output delay_tune_pkg::delay_arr_t delay_value,
  output delay_tune_pkg::delay_val_t led_output
);
  import delay_tune_pkg::*;

  delay_val_t cur_val;
  delay_val_t next_val;

  // One count up or down with wrap at 0 and DELAY_MAX
  function automatic delay_val_t step_val(
    input delay_val_t v,
    input logic       up
  );
    delay_val_t r;
    if (up)
      r = (v >= DELAY_MAX) ? '0 : v + 1'b1;
    else
      r = (v == '0) ? DELAY_MAX : v - 1'b1;
    return r;
  endfunction

  assign cur_val  = delay_value[adj.cmd_ch]; // Value before the command
  assign next_val = step_val(cur_val, adj.cmd_up);

  // --------------------
  // Storage
  // --------------------
  always_ff @(posedge clk_x10)
  begin
    if (g_rst)
    begin
      delay_value <= '0;
      led_output  <= '0;
    end
    else if (adj.cmd_valid)
    begin
      led_output <= cur_val;
      if (adj.cmd_step)
        delay_value[adj.cmd_ch] <= next_val;
    end
    // LED keeps its last value between commands and after timeout
  end

endmodule

//--- verilog/delay_select_ctrl.sv
// --------------------
// Selection controller
// Turns press pulses into show or step commands
// and drops the selection after an idle time
// --------------------
`timescale 1ns/1ps

module delay_select_ctrl #(
  parameter int unsigned IDLE_CYCLES = 400_000_000
) (
  input  logic                              clk_x10,
  input  logic                              g_rst,
  input  logic [delay_tune_pkg::NUM_CH-1:0] press,
  input  logic                              inverse_sync,
  adjust_if.ctrl                            adj
);
  import delay_tune_pkg::*;

  localparam int IDLE_W = $clog2(IDLE_CYCLES + 1);

  logic              single;
  ch_idx_t           press_ch;
  logic              sel_valid;
  ch_idx_t           sel_ch;
  logic [IDLE_W-1:0] idle_cnt;
  logic              idle_done;

  // --------------------
  // Press decode
  // --------------------
  assign single = $onehot(press); // Simultaneous presses are dropped

  always_comb
  begin
    press_ch = '0;
    for (int i = 0; i < NUM_CH; i++)
    begin
      if (press[i])
        press_ch = ch_idx_t'(i);
    end
  end

  // Last idle cycle before timeout
  assign idle_done = (press == '0) && (idle_cnt == IDLE_W'(IDLE_CYCLES - 1));

  // --------------------
  // Selection and idle timer
  // --------------------
  always_ff @(posedge clk_x10)
  begin
    if (g_rst)
    begin
      adj.cmd_valid <= 1'b0;
      sel_valid     <= 1'b0;
      sel_ch        <= '0;
      idle_cnt      <= '0;
    end
    else
    begin
      adj.cmd_valid <= single;
      if (press != '0)
        idle_cnt <= '0;
      else if (idle_cnt != IDLE_W'(IDLE_CYCLES))
        idle_cnt <= idle_cnt + 1'b1; // Saturates at timeout
      if (single)
      begin
        sel_valid <= 1'b1;
        sel_ch    <= press_ch;
      end
      else if (idle_done)
      begin
        sel_valid <= 1'b0;
      end
    end
  end

  // Command payload, qualified by cmd_valid
  always_ff @(posedge clk_x10)
  begin
    if (single)
    begin
      adj.cmd_ch   <= press_ch;
      adj.cmd_step <= sel_valid && (sel_ch == press_ch);
      adj.cmd_up   <= inverse_sync;
    end
  end

endmodule

//--- verilog/key_debounce.sv
// --------------------
// Key debouncer
// Accepts a new key level after it has been stable
// for DEBOUNCE_CYCLES and pulses once per press
// --------------------
`timescale 1ns/1ps

module key_debounce #(
  parameter int unsigned DEBOUNCE_CYCLES = 1_000_000
) (
  input  logic clk_x10,
  input  logic g_rst,
  input  logic key,
  output logic key_pulse
);

  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic             key_level; // Accepted level
  logic [CNT_W-1:0] stable_cnt;
  logic             accept;

  // Count reached while the key still differs from the accepted level
  assign accept = (key != key_level) && (stable_cnt == CNT_W'(DEBOUNCE_CYCLES));

  always_ff @(posedge clk_x10)
  begin
    if (g_rst)
    begin
      key_level  <= 1'b0;
      stable_cnt <= '0;
      key_pulse  <= 1'b0;
    end
    else
    begin
      key_pulse <= accept && key; // Release gives no pulse
      if (key == key_level)
      begin
        stable_cnt <= '0;         // Bounce back restarts the count
      end
      else if (accept)
      begin
        key_level  <= key;
        stable_cnt <= '0;
      end
      else
      begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end
  end

endmodule

//--- verilog/button_sync.sv
// --------------------
// Panel input synchronizer
// Two flops on every button and on the
// inverse switch
// --------------------
`timescale 1ns/1ps

module button_sync (
  input  logic                              clk_x10,
  input  logic                              g_rst,
  input  logic [delay_tune_pkg::NUM_CH-1:0] buttons,
  input  logic                              inverse,
  output logic [delay_tune_pkg::NUM_CH-1:0] buttons_sync,
  output logic                              inverse_sync
);
  import delay_tune_pkg::*;

  logic [NUM_CH-1:0] buttons_meta;
  logic              inverse_meta;

  always_ff @(posedge clk_x10)
  begin
    if (g_rst)
    begin
      buttons_meta <= '0;
      buttons_sync <= '0;
      inverse_meta <= 1'b0;
      inverse_sync <= 1'b0;
    end
    else
    begin
      buttons_meta <= buttons;      // First stage may go metastable
      buttons_sync <= buttons_meta;
      inverse_meta <= inverse;
      inverse_sync <= inverse_meta;
    end
  end

endmodule

//--- verilog/adjust_if.sv
// --------------------
// Adjust command bus
// Carries show and step commands from the
// selection controller to the value bank
// --------------------
`timescale 1ns/1ps

interface adjust_if;
  import delay_tune_pkg::*;

  logic    cmd_valid; // One-cycle pulse, always accepted
  ch_idx_t cmd_ch;
  logic    cmd_step;  // Low means show only
  logic    cmd_up;

  modport ctrl (
    output cmd_valid,
    output cmd_ch,
    output cmd_step,
    output cmd_up
  );

  modport bank (
    input cmd_valid,
    input cmd_ch,
    input cmd_step,
    input cmd_up
  );

endinterface

//--- verilog/delay_tune_pkg.sv
// --------------------
// Delay tune package
// Channel count, value width, wrap limit and the
// shared channel and value types of the delay panel
// --------------------

package delay_tune_pkg;

  // Panel geometry
  localparam int NUM_CH  = 9;
  localparam int DELAY_W = 4;
  localparam int CH_W    = 4;

  // Channel index; 8 is r_whole and 0 is b_falling
  typedef logic [CH_W-1:0] ch_idx_t;

  // One delay setting
  typedef logic [DELAY_W-1:0] delay_val_t;

  // All settings; element i belongs to channel i
  typedef delay_val_t [NUM_CH-1:0] delay_arr_t;

  // Steps wrap between 0 and this limit
  localparam delay_val_t DELAY_MAX = DELAY_W'(10);

endpackage
